//--- filelist.f
+incdir+hw
hw/mlpPkg.sv
hw/featureBuffer.sv
hw/denseNode.sv
hw/classArgmax.sv
hw/inferenceControl.sv
hw/mlpClassifier.sv
tb/mlpClassifier_properties.sv
tb/mlpClassifierTb.sv

//--- hw/classArgmax.sv
`timescale 1ns/1ps
`default_nettype none

module classArgmax
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input activation_t score0,
	input activation_t score1,
	input activation_t score2,
	output classIndex_t classOut
);

	activation_t bestScore;
	classIndex_t bestIndex;

	// strict compare so ties keep the lower index.
	always_comb
	begin
		bestScore = score0;
		bestIndex = 2'd0;
		if (score1 > bestScore)
		begin
			bestScore = score1;
			bestIndex = 2'd1;
		end
		if (score2 > bestScore)
		begin
			bestIndex = 2'd2;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classOut <= '0;
		end
		else
		begin
			classOut <= bestIndex;
		end
	end

endmodule

`default_nettype wire

//--- hw/denseNode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlp_config.svh"

module denseNode
	import mlpPkg::*;
#(
	parameter int FAN_IN = 15,
	parameter weight_t [FAN_IN-1:0] WEIGHTS = '0,
	parameter weight_t BIAS = '0
)
(
	input logic clk,
	input logic reset,
	input activation_t [FAN_IN-1:0] nodeIn,
	output activation_t nodeOut
);

	// width of the rescaled result.
	localparam int OUT_BITS = 16;

	activation_t [FAN_IN-1:0] inReg;
	logic [31:0] sumReg;
	logic [31:0] sumNext;
	logic [OUT_BITS-1:0] scaled;

	// wraps at 32 bits like the products.
	always_comb
	begin
		sumNext = BIAS;
		for (int i = 0; i < FAN_IN; i++)
		begin
			sumNext = sumNext + inReg[i] * WEIGHTS[i];
		end
	end

	// drop the fraction bits, keep 16 bits of integer part.
	assign scaled = sumReg[`MLP_FRAC_SHIFT +: OUT_BITS];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inReg <= '0;
			sumReg <= '0;
			nodeOut <= '0;
		end
		else
		begin
			inReg <= nodeIn;
			sumReg <= sumNext;
			// relu on the sign bit.
			if (!sumReg[31])
			begin
				nodeOut <= {{(32 - OUT_BITS){1'b0}}, scaled};
			end
			else
			begin
				nodeOut <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/featureBuffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlp_config.svh"

module featureBuffer
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input activation_t featureIn,
	input logic featureStrobe,
	output activation_t feature0,
	output activation_t feature1,
	output activation_t feature2,
	output activation_t feature3,
	output activation_t feature4,
	output activation_t feature5,
	output activation_t feature6,
	output activation_t feature7,
	output activation_t feature8,
	output activation_t feature9,
	output activation_t feature10,
	output activation_t feature11,
	output activation_t feature12,
	output activation_t feature13,
	output activation_t feature14
);

	activation_t words [`MLP_FEATURES];

	// new words enter at the top and the oldest ends in slot 0.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `MLP_FEATURES; i++)
			begin
				words[i] <= '0;
			end
		end
		else if (featureStrobe)
		begin
			for (int i = 0; i < `MLP_FEATURES - 1; i++)
			begin
				words[i] <= words[i + 1];
			end
			words[`MLP_FEATURES - 1] <= featureIn;
		end
	end

	assign feature0 = words[0];
	assign feature1 = words[1];
	assign feature2 = words[2];
	assign feature3 = words[3];
	assign feature4 = words[4];
	assign feature5 = words[5];
	assign feature6 = words[6];
	assign feature7 = words[7];
	assign feature8 = words[8];
	assign feature9 = words[9];
	assign feature10 = words[10];
	assign feature11 = words[11];
	assign feature12 = words[12];
	assign feature13 = words[13];
	assign feature14 = words[14];

endmodule

`default_nettype wire

//--- hw/inferenceControl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlp_config.svh"

module inferenceControl
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input logic featureStrobe,
	output logic resultValid,
	output sampleCount_t sampleCount
);

	localparam int COUNT_W = $clog2(`MLP_FEATURES);
	localparam logic [COUNT_W-1:0] LAST_INDEX = COUNT_W'(`MLP_FEATURES - 1);

	controlState_t state;
	controlState_t stateNext;
	logic [COUNT_W-1:0] featureCount;
	logic [`MLP_PIPE_DEPTH-1:0] inFlight;
	logic lastFeature;

	// strobe that completes a sample.
	assign lastFeature = featureStrobe && (state == collecting) && (featureCount == LAST_INDEX);

	always_comb
	begin
		stateNext = state;
		case (state)
			idle:
			begin
				if (featureStrobe)
				begin
					stateNext = collecting;
				end
			end
			collecting:
			begin
				if (lastFeature)
				begin
					stateNext = draining;
				end
			end
			draining:
			begin
				// a new sample may start while older ones are still in the pipe.
				if (featureStrobe)
				begin
					stateNext = collecting;
				end
				else if (inFlight == '0)
				begin
					stateNext = idle;
				end
			end
			default:
			begin
				stateNext = idle;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			featureCount <= '0;
		end
		else
		begin
			state <= stateNext;
			if (featureStrobe)
			begin
				if (state != collecting)
				begin
					featureCount <= COUNT_W'(1);
				end
				else if (lastFeature)
				begin
					featureCount <= '0;
				end
				else
				begin
					featureCount <= featureCount + 1'b1;
				end
			end
		end
	end

	// one bit per sample in flight, as deep as the node and argmax latency.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inFlight <= '0;
			resultValid <= 1'b0;
			sampleCount <= '0;
		end
		else
		begin
			inFlight <= {inFlight[`MLP_PIPE_DEPTH-2:0], lastFeature};
			resultValid <= inFlight[`MLP_PIPE_DEPTH-1];
			if (inFlight[`MLP_PIPE_DEPTH-1])
			begin
				sampleCount <= sampleCount + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/mlpClassifier.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlp_config.svh"

module mlpClassifier
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input activation_t featureIn,
	input logic featureStrobe,
	output logic resultValid,
	output classIndex_t classOut,
	output activation_t scoreOut0,
	output activation_t scoreOut1,
	output activation_t scoreOut2,
	output sampleCount_t sampleCount
);

	activation_t feature0;
	activation_t feature1;
	activation_t feature2;
	activation_t feature3;
	activation_t feature4;
	activation_t feature5;
	activation_t feature6;
	activation_t feature7;
	activation_t feature8;
	activation_t feature9;
	activation_t feature10;
	activation_t feature11;
	activation_t feature12;
	activation_t feature13;
	activation_t feature14;
	activation_t hidden0;
	activation_t hidden1;
	activation_t hidden2;
	activation_t hidden3;

	featureBuffer featureBuffer_i (
		.clk(clk),
		.reset(reset),
		.featureIn(featureIn),
		.featureStrobe(featureStrobe),
		.feature0(feature0),
		.feature1(feature1),
		.feature2(feature2),
		.feature3(feature3),
		.feature4(feature4),
		.feature5(feature5),
		.feature6(feature6),
		.feature7(feature7),
		.feature8(feature8),
		.feature9(feature9),
		.feature10(feature10),
		.feature11(feature11),
		.feature12(feature12),
		.feature13(feature13),
		.feature14(feature14)
	);

	// all four hidden nodes see the same feature vector.
	denseNode #(.FAN_IN(`MLP_FEATURES), .WEIGHTS(`MLP_H0_W), .BIAS(`MLP_H0_B)) hiddenNode0_i (
		.clk(clk),
		.reset(reset),
		.nodeIn({feature14, feature13, feature12, feature11, feature10, feature9, feature8,
			feature7, feature6, feature5, feature4, feature3, feature2, feature1, feature0}),
		.nodeOut(hidden0)
	);

	denseNode #(.FAN_IN(`MLP_FEATURES), .WEIGHTS(`MLP_H1_W), .BIAS(`MLP_H1_B)) hiddenNode1_i (
		.clk(clk),
		.reset(reset),
		.nodeIn({feature14, feature13, feature12, feature11, feature10, feature9, feature8,
			feature7, feature6, feature5, feature4, feature3, feature2, feature1, feature0}),
		.nodeOut(hidden1)
	);

	denseNode #(.FAN_IN(`MLP_FEATURES), .WEIGHTS(`MLP_H2_W), .BIAS(`MLP_H2_B)) hiddenNode2_i (
		.clk(clk),
		.reset(reset),
		.nodeIn({feature14, feature13, feature12, feature11, feature10, feature9, feature8,
			feature7, feature6, feature5, feature4, feature3, feature2, feature1, feature0}),
		.nodeOut(hidden2)
	);

	denseNode #(.FAN_IN(`MLP_FEATURES), .WEIGHTS(`MLP_H3_W), .BIAS(`MLP_H3_B)) hiddenNode3_i (
		.clk(clk),
		.reset(reset),
		.nodeIn({feature14, feature13, feature12, feature11, feature10, feature9, feature8,
			feature7, feature6, feature5, feature4, feature3, feature2, feature1, feature0}),
		.nodeOut(hidden3)
	);

	// output layer.
	denseNode #(.FAN_IN(`MLP_HIDDEN), .WEIGHTS(`MLP_O0_W), .BIAS(`MLP_O0_B)) outputNode0_i (
		.clk(clk),
		.reset(reset),
		.nodeIn({hidden3, hidden2, hidden1, hidden0}),
		.nodeOut(scoreOut0)
	);

	denseNode #(.FAN_IN(`MLP_HIDDEN), .WEIGHTS(`MLP_O1_W), .BIAS(`MLP_O1_B)) outputNode1_i (
		.clk(clk),
		.reset(reset),
		.nodeIn({hidden3, hidden2, hidden1, hidden0}),
		.nodeOut(scoreOut1)
	);

	denseNode #(.FAN_IN(`MLP_HIDDEN), .WEIGHTS(`MLP_O2_W), .BIAS(`MLP_O2_B)) outputNode2_i (
		.clk(clk),
		.reset(reset),
		.nodeIn({hidden3, hidden2, hidden1, hidden0}),
		.nodeOut(scoreOut2)
	);

	classArgmax classArgmax_i (
		.clk(clk),
		.reset(reset),
		.score0(scoreOut0),
		.score1(scoreOut1),
		.score2(scoreOut2),
		.classOut(classOut)
	);

	inferenceControl inferenceControl_i (
		.clk(clk),
		.reset(reset),
		.featureStrobe(featureStrobe),
		.resultValid(resultValid),
		.sampleCount(sampleCount)
	);

endmodule

`default_nettype wire

//--- hw/mlpPkg.sv
`default_nettype none

package mlpPkg;

	// node outputs only fill the low 16 bits.
	typedef logic [31:0] activation_t;

	// two's complement value held as a plain vector.
	typedef logic [31:0] weight_t;

	typedef logic [1:0] classIndex_t;

	typedef logic [15:0] sampleCount_t;

	typedef enum logic [1:0] {
		idle,
		collecting,
		draining
	} controlState_t;

endpackage

`default_nettype wire

//--- hw/mlp_config.svh
`ifndef MLP_CONFIG_SVH
`define MLP_CONFIG_SVH

// network shape.
`define MLP_FEATURES 15
`define MLP_HIDDEN 4
`define MLP_CLASSES 3
`define MLP_FRAC_SHIFT 13

// edge taking the last feature to the resultValid edge.
`define MLP_PIPE_DEPTH 7

// weight lists start with the highest input so input 0 sits in the low bits.
`define MLP_H0_W { \
	-32'sd350, 32'sd1790, 32'sd476, -32'sd2210, 32'sd1333, \
	-32'sd512, 32'sd2048, 32'sd905, -32'sd1785, 32'sd3310, \
	-32'sd96, 32'sd640, 32'sd2375, -32'sd1420, 32'sd812 }
`define MLP_H0_B 32'sd512

`define MLP_H1_W { \
	32'sd3390, -32'sd765, 32'sd1408, -32'sd97, 32'sd2210, \
	32'sd844, -32'sd3012, 32'sd1566, -32'sd289, 32'sd733, \
	32'sd4020, -32'sd1875, 32'sd118, 32'sd2950, -32'sd640 }
`define MLP_H1_B -32'sd1024

`define MLP_H2_W { \
	32'sd1245, 32'sd722, -32'sd1610, 32'sd3060, -32'sd233, \
	32'sd1975, -32'sd880, 32'sd415, 32'sd2690, -32'sd1340, \
	32'sd58, 32'sd3175, -32'sd2260, -32'sd410, 32'sd1520 }
`define MLP_H2_B 32'sd350

`define MLP_H3_W { \
	-32'sd1377, 32'sd2605, -32'sd36, 32'sd1480, 32'sd587, \
	-32'sd2045, 32'sd1012, 32'sd3320, 32'sd366, -32'sd1190, \
	32'sd2540, -32'sd455, 32'sd1738, 32'sd904, -32'sd2875 }
`define MLP_H3_B 32'sd128

`define MLP_O0_W {-32'sd615, 32'sd2988, -32'sd1736, 32'sd4210}
`define MLP_O0_B -32'sd420
`define MLP_O1_W {32'sd2460, -32'sd702, 32'sd3875, -32'sd1294}
`define MLP_O1_B 32'sd275
`define MLP_O2_W {32'sd3315, -32'sd3140, 32'sd955, 32'sd1860}
`define MLP_O2_B -32'sd130

`endif

//--- tb/mlpClassifierTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlp_config.svh"

module mlpClassifierTb
	import mlpPkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int TEST_CYCLES = 400;
	localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD * 2 + 2000;

	// index 0 of each list is input 0.
	localparam weight_t [`MLP_HIDDEN-1:0][`MLP_FEATURES-1:0] HIDDEN_W =
		{`MLP_H3_W, `MLP_H2_W, `MLP_H1_W, `MLP_H0_W};
	localparam weight_t [`MLP_HIDDEN-1:0] HIDDEN_B =
		{`MLP_H3_B, `MLP_H2_B, `MLP_H1_B, `MLP_H0_B};
	localparam weight_t [`MLP_CLASSES-1:0][`MLP_HIDDEN-1:0] OUT_W =
		{`MLP_O2_W, `MLP_O1_W, `MLP_O0_W};
	localparam weight_t [`MLP_CLASSES-1:0] OUT_B = {`MLP_O2_B, `MLP_O1_B, `MLP_O0_B};

	logic clk;
	logic reset;
	activation_t featureIn;
	logic featureStrobe;
	logic resultValid;
	classIndex_t classOut;
	activation_t scoreOut0;
	activation_t scoreOut1;
	activation_t scoreOut2;
	sampleCount_t sampleCount;

	int cycleCount = 0;
	int expectedCount = 0;
	int samplesSent = 0;
	int negativeOutputs = 0;
	int expectCycleQ [$];
	classIndex_t expectClassQ [$];
	activation_t expectScore0Q [$];
	activation_t expectScore1Q [$];
	activation_t expectScore2Q [$];
	activation_t lastScore0 = '0;
	activation_t lastScore1 = '0;
	activation_t lastScore2 = '0;

	mlpClassifier mlpClassifier_i (
		.clk(clk),
		.reset(reset),
		.featureIn(featureIn),
		.featureStrobe(featureStrobe),
		.resultValid(resultValid),
		.classOut(classOut),
		.scoreOut0(scoreOut0),
		.scoreOut1(scoreOut1),
		.scoreOut2(scoreOut2),
		.sampleCount(sampleCount)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
	end

	task automatic failRun(input string message);
		$display("%s", message);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic compareActivation(input string name, input activation_t expected,
		input activation_t actual);
		if (actual !== expected)
		begin
			failRun($sformatf("Fail %0t %s expected %0h actual %0h",
				$time, name, expected, actual));
		end
	endtask

	task automatic compareClass(input string name, input classIndex_t expected,
		input classIndex_t actual);
		if (actual !== expected)
		begin
			failRun($sformatf("Fail %0t %s expected %0d actual %0d",
				$time, name, expected, actual));
		end
	endtask

	task automatic compareCount(input string name, input sampleCount_t expected,
		input sampleCount_t actual);
		if (actual !== expected)
		begin
			failRun($sformatf("Fail %0t %s expected %0d actual %0d",
				$time, name, expected, actual));
		end
	endtask

	// wrap-around weighted sum with bias.
	function automatic logic [31:0] nodeSum(input weight_t [`MLP_FEATURES-1:0] weights,
		input weight_t bias, input activation_t inputs [`MLP_FEATURES], input int fanIn);
		logic [31:0] acc;
		acc = bias;
		for (int i = 0; i < fanIn; i++)
		begin
			acc = acc + inputs[i] * weights[i];
		end
		return acc;
	endfunction

	function automatic activation_t reluRescale(input logic [31:0] sum);
		activation_t shifted;
		shifted = sum >> `MLP_FRAC_SHIFT;
		return sum[31] ? '0 : (shifted & 32'h0000_ffff);
	endfunction

	task automatic predictSample(input activation_t features [`MLP_FEATURES]);
		activation_t hidden [`MLP_FEATURES];
		activation_t scores [`MLP_CLASSES];
		weight_t [`MLP_FEATURES-1:0] outWeights;
		logic [31:0] sum;
		classIndex_t best;
		foreach (hidden[i])
		begin
			hidden[i] = '0;
		end
		for (int h = 0; h < `MLP_HIDDEN; h++)
		begin
			hidden[h] = reluRescale(nodeSum(HIDDEN_W[h], HIDDEN_B[h], features, `MLP_FEATURES));
		end
		negativeOutputs = 0;
		for (int o = 0; o < `MLP_CLASSES; o++)
		begin
			outWeights = '0;
			outWeights[`MLP_HIDDEN-1:0] = OUT_W[o];
			sum = nodeSum(outWeights, OUT_B[o], hidden, `MLP_HIDDEN);
			negativeOutputs += sum[31];
			scores[o] = reluRescale(sum);
		end
		// strict compare so the lowest index wins a tie.
		best = 2'd0;
		for (int o = 1; o < `MLP_CLASSES; o++)
		begin
			if (scores[o] > scores[best])
			begin
				best = classIndex_t'(o);
			end
		end
		expectCycleQ.push_back(cycleCount + 1);
		expectClassQ.push_back(best);
		expectScore0Q.push_back(scores[0]);
		expectScore1Q.push_back(scores[1]);
		expectScore2Q.push_back(scores[2]);
	endtask

	// starts right after a falling edge.
	task automatic driveFeatures(input activation_t features [`MLP_FEATURES], input int count,
		input int maxGap);
		int gap;
		for (int i = 0; i < count; i++)
		begin
			featureIn = features[i];
			featureStrobe = 1'b1;
			if (i == `MLP_FEATURES - 1)
			begin
				predictSample(features);
				samplesSent++;
			end
			@(negedge clk);
			featureStrobe = 1'b0;
			gap = (maxGap > 0) ? int'($urandom_range(0, maxGap)) : 0;
			repeat (gap) @(negedge clk);
		end
	endtask

	task automatic checkResult();
		int startCycle;
		if (expectCycleQ.size() == 0)
		begin
			failRun("resultValid pulsed with no sample pending");
		end
		else
		begin
			startCycle = expectCycleQ.pop_front();
			if (cycleCount != startCycle + `MLP_PIPE_DEPTH)
			begin
				failRun($sformatf("resultValid came %0d cycles after the last feature, not %0d",
					cycleCount - startCycle, `MLP_PIPE_DEPTH));
			end
			expectedCount++;
			compareClass("classOut", expectClassQ.pop_front(), classOut);
			// scores settle one cycle before the pulse.
			compareActivation("scoreOut0", expectScore0Q.pop_front(), lastScore0);
			compareActivation("scoreOut1", expectScore1Q.pop_front(), lastScore1);
			compareActivation("scoreOut2", expectScore2Q.pop_front(), lastScore2);
			compareCount("sampleCount", sampleCount_t'(expectedCount), sampleCount);
		end
	endtask

	initial
	begin
		forever
		begin
			@(negedge clk);
			if (mlpClassifier_i.mlpClassifierProperties_i.failureCount != 0)
			begin
				failRun("bound assertions reported failures");
			end
			if (!reset && resultValid)
			begin
				checkResult();
			end
			if (expectCycleQ.size() != 0 && cycleCount > expectCycleQ[0] + `MLP_PIPE_DEPTH + 2)
			begin
				failRun($sformatf("no resultValid within %0d cycles of the last feature",
					`MLP_PIPE_DEPTH + 2));
			end
			lastScore0 = scoreOut0;
			lastScore1 = scoreOut1;
			lastScore2 = scoreOut2;
		end
	end

	task automatic waitResults();
		while (expectCycleQ.size() != 0)
		begin
			@(negedge clk);
		end
		repeat (3) @(negedge clk);
		compareCount("sampleCount", sampleCount_t'(samplesSent), sampleCount);
	endtask

	task automatic applyReset(input int cycles);
		reset = 1'b1;
		featureStrobe = 1'b0;
		repeat (cycles) @(negedge clk);
		reset = 1'b0;
		expectedCount = 0;
		samplesSent = 0;
		expectCycleQ.delete();
		expectClassQ.delete();
		expectScore0Q.delete();
		expectScore1Q.delete();
		expectScore2Q.delete();
	endtask

	task automatic randomFeatures(output activation_t features [`MLP_FEATURES]);
		foreach (features[i])
		begin
			features[i] = $urandom_range(0, 32'h0000_ffff);
		end
	endtask

	task automatic checkIdleAfterReset();
		repeat (10)
		begin
			@(negedge clk);
			compareCount("sampleCount", '0, sampleCount);
			compareActivation("scoreOut0", '0, scoreOut0);
			compareActivation("scoreOut1", '0, scoreOut1);
			compareActivation("scoreOut2", '0, scoreOut2);
		end
	endtask

	task automatic runContiguousSample();
		activation_t features [`MLP_FEATURES];
		foreach (features[i])
		begin
			features[i] = 32'(i * 4321 + 777);
		end
		driveFeatures(features, `MLP_FEATURES, 0);
		waitResults();
	endtask

	task automatic runNegativeSumSample();
		activation_t features [`MLP_FEATURES];
		foreach (features[i])
		begin
			features[i] = '0;
		end
		driveFeatures(features, `MLP_FEATURES, 0);
		if (negativeOutputs == 0)
		begin
			failRun("zero sample left no output node with a negative sum");
		end
		waitResults();
		compareActivation("scoreOut0", '0, scoreOut0);
		compareActivation("scoreOut1", '0, scoreOut1);
		compareActivation("scoreOut2", '0, scoreOut2);
		compareClass("classOut", 2'd0, classOut);
	endtask

	task automatic runSpacedSample();
		activation_t features [`MLP_FEATURES];
		randomFeatures(features);
		driveFeatures(features, `MLP_FEATURES, 3);
		waitResults();
	endtask

	task automatic runBackToBackSamples();
		activation_t features [`MLP_FEATURES];
		repeat (10)
		begin
			randomFeatures(features);
			driveFeatures(features, `MLP_FEATURES, 0);
		end
		waitResults();
	endtask

	task automatic runMidSampleReset();
		activation_t features [`MLP_FEATURES];
		randomFeatures(features);
		driveFeatures(features, 7, 0);
		applyReset(4);
		// monitor flags any pulse from the cut sample.
		repeat (12) @(negedge clk);
		compareCount("sampleCount", '0, sampleCount);
		randomFeatures(features);
		driveFeatures(features, `MLP_FEATURES, 1);
		waitResults();
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		failRun("watchdog expired before the tests finished");
	end

	initial
	begin
		void'($urandom(32'hc76e));
		featureIn = '0;
		featureStrobe = 1'b0;
		applyReset(8);
		checkIdleAfterReset();
		runContiguousSample();
		runNegativeSumSample();
		runSpacedSample();
		runBackToBackSamples();
		runMidSampleReset();
		repeat (5) @(negedge clk);
		if (mlpClassifier_i.mlpClassifierProperties_i.failureCount != 0)
		begin
			failRun("bound assertions reported failures");
		end
		else
		begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- tb/mlpClassifier_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlp_config.svh"

module mlpClassifierProperties
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input logic resultValid,
	input classIndex_t classOut,
	input sampleCount_t sampleCount
);

	int failureCount = 0;

	// covers the reset cycles and the first cycle out of reset.
	quietInReset: assert property (@(posedge clk) reset |=> !resultValid)
	else
	begin
		failureCount++;
		$error("resultValid high during or right after reset");
	end

	singlePulse: assert property (@(posedge clk) disable iff (reset) resultValid |=> !resultValid)
	else
	begin
		failureCount++;
		$error("resultValid high for two cycles in a row");
	end

	legalClass: assert property (@(posedge clk) disable iff (reset) classOut < `MLP_CLASSES)
	else
	begin
		failureCount++;
		$error("classOut holds an index past the last class");
	end

	// count moves on the same edge as the pulse.
	countFollowsPulse: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |->
		sampleCount == sampleCount_t'($past(sampleCount) + sampleCount_t'(resultValid)))
	else
	begin
		failureCount++;
		$error("sampleCount did not step with resultValid");
	end

endmodule

bind mlpClassifier mlpClassifierProperties mlpClassifierProperties_i (
	.clk(clk),
	.reset(reset),
	.resultValid(resultValid),
	.classOut(classOut),
	.sampleCount(sampleCount)
);

`default_nettype wire
